//--- rtl/cfg_bus_pkg.sv
package cfg_bus_pkg;

    localparam int CFG_ADDR_W  = 32;
    localparam int CFG_DATA_W  = 32;
    localparam int CFG_ID_W    = 3;
    localparam int CFG_ID_LSB  = 29;    // Slave ID sits in addr[31:29]
    localparam int CFG_OFS_W   = 8;
    localparam int CFG_OFS_LSB = 2;     // Word offset, byte bits dropped

    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
    typedef logic [CFG_DATA_W-1:0] cfg_data_t;
    typedef logic [CFG_ID_W-1:0]   cfg_slv_id_t;
    typedef logic [CFG_OFS_W-1:0]  cfg_ofs_t;

    // AXI response encoding
    typedef enum logic [1:0] {
        CFG_RESP_OKAY   = 2'b00,
        CFG_RESP_DECERR = 2'b11
    } cfg_resp_e;

    // Request from the master port
    typedef struct packed {
        logic      write;
        cfg_addr_t addr;
        cfg_data_t wdata;
    } cfg_req_t;

    // Request broadcast to the banks
    typedef struct packed {
        logic      write;
        cfg_ofs_t  ofs;
        cfg_data_t wdata;
    } cfg_slv_req_t;

    typedef struct packed {
        cfg_resp_e resp;
        cfg_data_t rdata;
    } cfg_rsp_t;

endpackage

//--- rtl/cfg_addr_decoder.sv
module cfg_addr_decoder
    import cfg_bus_pkg::*;
#(
    parameter int SLV_AMT = 5
) (
    input  logic                sys_clk,
    input  logic                rst_n_i,
    input  logic                req_valid_i,
    input  cfg_req_t            req_i,
    output logic [SLV_AMT-1:0]  bank_sel_o,
    output cfg_slv_req_t        slv_req_o,
    output logic                ctx_valid_o,
    output cfg_slv_id_t         ctx_id_o,
    output logic                ctx_decerr_o
);

    cfg_slv_id_t        req_id;
    cfg_ofs_t           req_ofs;
    logic               id_hit;
    logic [SLV_AMT-1:0] sel_d;

    assign req_id  = req_i.addr[CFG_ID_LSB +: CFG_ID_W];
    assign req_ofs = req_i.addr[CFG_OFS_LSB +: CFG_OFS_W];   // Other address bits ignored

    // One-hot select, nothing set for an unmapped ID
    always_comb begin
        sel_d  = '0;
        id_hit = 1'b0;
        for (int i = 0; i < SLV_AMT; i++) begin
            if (req_id == cfg_slv_id_t'(i)) begin
                sel_d[i] = req_valid_i;
                id_hit   = 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            bank_sel_o   <= '0;
            ctx_valid_o  <= 1'b0;
            ctx_decerr_o <= 1'b0;
        end else begin
            bank_sel_o   <= sel_d;
            ctx_valid_o  <= req_valid_i;
            ctx_decerr_o <= req_valid_i && !id_hit;
        end
    end

    // Payload for banks and response mux
    always_ff @(posedge sys_clk) begin
        if (req_valid_i) begin
            slv_req_o.write <= req_i.write;
            slv_req_o.ofs   <= req_ofs;
            slv_req_o.wdata <= req_i.wdata;
            ctx_id_o        <= req_id;
        end
    end

endmodule

//--- rtl/cfg_reg_bank.sv
module cfg_reg_bank
    import cfg_bus_pkg::*;
#(
    parameter int REG_AMT = 4
) (
    input  logic         sys_clk,
    input  logic         rst_n_i,
    input  logic         sel_i,
    input  cfg_slv_req_t slv_req_i,
    output cfg_data_t    rdata_o
);

    localparam int IDX_W = (REG_AMT > 1) ? $clog2(REG_AMT) : 1;

    cfg_data_t        regs [REG_AMT];
    logic [IDX_W-1:0] idx;
    cfg_data_t        rd_word;

    // Upper offset bits fall outside this bank
    assign idx = slv_req_i.ofs[IDX_W-1:0];

    always_comb begin
        rd_word = '0;
        for (int i = 0; i < REG_AMT; i++) begin
            if (idx == IDX_W'(i)) begin
                rd_word = regs[i];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_AMT; i++) begin
                regs[i] <= '0;
            end
            rdata_o <= '0;
        end else if (sel_i) begin
            if (slv_req_i.write) begin
                for (int i = 0; i < REG_AMT; i++) begin
                    if (idx == IDX_W'(i)) begin
                        regs[i] <= slv_req_i.wdata;
                    end
                end
                rdata_o <= '0;          // Write response carries no data
            end else begin
                rdata_o <= rd_word;
            end
        end
    end

endmodule

//--- rtl/cfg_rsp_mux.sv
module cfg_rsp_mux
    import cfg_bus_pkg::*;
#(
    parameter int SLV_AMT = 5
) (
    input  logic                      sys_clk,
    input  logic                      rst_n_i,
    input  logic                      ctx_valid_i,
    input  cfg_slv_id_t               ctx_id_i,
    input  logic                      ctx_decerr_i,
    input  cfg_data_t [SLV_AMT-1:0]   bank_rdata_i,
    output logic                      rsp_valid_o,
    output cfg_rsp_t                  rsp_o
);

    logic        ctx_valid_q;
    logic        ctx_decerr_q;
    cfg_slv_id_t ctx_id_q;
    cfg_data_t   sel_rdata;

    // Context delayed to meet the bank read data
    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            ctx_valid_q  <= 1'b0;
            ctx_decerr_q <= 1'b0;
        end else begin
            ctx_valid_q  <= ctx_valid_i;
            ctx_decerr_q <= ctx_decerr_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (ctx_valid_i) begin
            ctx_id_q <= ctx_id_i;
        end
    end

    always_comb begin
        sel_rdata = '0;
        for (int i = 0; i < SLV_AMT; i++) begin
            if (ctx_id_q == cfg_slv_id_t'(i)) begin
                sel_rdata = bank_rdata_i[i];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= ctx_valid_q;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (ctx_valid_q) begin
            if (ctx_decerr_q) begin
                rsp_o.resp  <= CFG_RESP_DECERR;
                rsp_o.rdata <= '0;
            end else begin
                rsp_o.resp  <= CFG_RESP_OKAY;
                rsp_o.rdata <= sel_rdata;
            end
        end
    end

endmodule

//--- rtl/cfg_bus_top.sv
module cfg_bus_top
    import cfg_bus_pkg::*;
#(
    parameter int SLV_AMT = 5,
    parameter int REG_AMT = 4
) (
    input  logic     sys_clk,
    input  logic     rst_n_i,
    input  logic     req_valid_i,
    input  cfg_req_t req_i,
    output logic     rsp_valid_o,
    output cfg_rsp_t rsp_o
);

    // Decoder outputs
    logic [SLV_AMT-1:0]      bank_sel;
    cfg_slv_req_t            slv_req;
    logic                    ctx_valid;
    cfg_slv_id_t             ctx_id;
    logic                    ctx_decerr;

    cfg_data_t [SLV_AMT-1:0] bank_rdata;

    cfg_addr_decoder #(
        .SLV_AMT      (SLV_AMT)
    ) u_dec (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .bank_sel_o   (bank_sel),
        .slv_req_o    (slv_req),
        .ctx_valid_o  (ctx_valid),
        .ctx_id_o     (ctx_id),
        .ctx_decerr_o (ctx_decerr)
    );

    // One bank per mapped slave ID
    for (genvar g = 0; g < SLV_AMT; g++) begin : g_bank
        cfg_reg_bank #(
            .REG_AMT   (REG_AMT)
        ) u_bank (
            .sys_clk   (sys_clk),
            .rst_n_i   (rst_n_i),
            .sel_i     (bank_sel[g]),
            .slv_req_i (slv_req),
            .rdata_o   (bank_rdata[g])
        );
    end

    cfg_rsp_mux #(
        .SLV_AMT      (SLV_AMT)
    ) u_mux (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .ctx_valid_i  (ctx_valid),
        .ctx_id_i     (ctx_id),
        .ctx_decerr_i (ctx_decerr),
        .bank_rdata_i (bank_rdata),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

endmodule

//--- verif/cfg_bus_assertions.sv
module cfg_bus_assertions
    import cfg_bus_pkg::*;
#(
    parameter int SLV_AMT = 5
) (
    input logic               sys_clk,
    input logic               rst_n_i,
    input logic               req_valid_i,
    input logic               rsp_valid_i,
    input cfg_rsp_t           rsp_i,
    input logic [SLV_AMT-1:0] bank_sel_i
);

    timeunit 1ns;
    timeprecision 100ps;

    a_rst_quiet: assert property (@(posedge sys_clk) !rst_n_i |=> !rsp_valid_i)
        else $error("rsp_valid_o high after a reset cycle");

    // Fixed three cycle latency, both directions
    a_req_to_rsp: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        req_valid_i |-> ##3 rsp_valid_i)
        else $error("Request not answered three cycles later");

    a_rsp_from_req: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        rsp_valid_i |-> $past(req_valid_i, 3))
        else $error("Response without a request three cycles earlier");

    a_decerr_zero: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        (rsp_valid_i && rsp_i.resp == CFG_RESP_DECERR) |-> rsp_i.rdata == '0)
        else $error("DECERR response with nonzero data");

    a_sel_onehot0: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        $onehot0(bank_sel_i))
        else $error("More than one bank selected");

endmodule

bind cfg_bus_top cfg_bus_assertions #(
    .SLV_AMT     (SLV_AMT)
) u_assert (
    .sys_clk     (sys_clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .rsp_valid_i (rsp_valid_o),
    .rsp_i       (rsp_o),
    .bank_sel_i  (bank_sel)
);

//--- verif/cfg_bus_tb.sv
module cfg_bus_tb
    import cfg_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          SLV_AMT    = 5;
    localparam int          REG_AMT    = 4;
    localparam int          RST_CYCLES = 16;
    localparam int          STIM_MAX   = 64;
    localparam int          STIM_COLS  = 5;   // op, addr, wdata, resp, rdata
    localparam logic [31:0] OP_END     = 32'hff;

    logic     sys_clk;
    logic     rst_n_i;
    logic     req_valid_i;
    cfg_req_t req_i;
    logic     rsp_valid_o;
    cfg_rsp_t rsp_o;

    logic [31:0] stim_mem [STIM_MAX*STIM_COLS];
    int          req_total = 0;
    int          cycle_cnt = 0;

    // Expected responses in request order
    logic [31:0] exp_resp_q [$];
    logic [31:0] exp_data_q [$];
    string       name_q [$];
    int          req_cyc_q [$];   // Cycle in which the DUT sampled each request

    cfg_bus_top #(
        .SLV_AMT     (SLV_AMT),
        .REG_AMT     (REG_AMT)
    ) dut_i (
        .sys_clk     (sys_clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Run aborted");
    endtask

    // Entries up to the end marker
    function automatic int count_requests();
        int n;
        n = 0;
        while (n < STIM_MAX && stim_mem[n*STIM_COLS] != OP_END) begin
            n++;
        end
        return n;
    endfunction

    task automatic send_request(input int idx);
        int          base;
        logic [31:0] op;
        base = idx * STIM_COLS;
        op   = stim_mem[base];
        @(posedge sys_clk);
        req_valid_i <= 1'b1;
        req_i.write <= op[0];
        req_i.addr  <= stim_mem[base+1];
        req_i.wdata <= stim_mem[base+2];
        exp_resp_q.push_back(stim_mem[base+3]);
        exp_data_q.push_back(stim_mem[base+4]);
        name_q.push_back($sformatf("req %0d %s %h", idx, op[0] ? "write" : "read",
                                   stim_mem[base+1]));
    endtask

    always @(posedge sys_clk) begin : rsp_monitor
        int          req_cyc;
        string       name;
        logic [31:0] exp_resp;
        logic [31:0] exp_data;
        if (req_valid_i === 1'b1) begin
            req_cyc_q.push_back(cycle_cnt);
        end
        if (rsp_valid_o === 1'b1) begin
            if (exp_resp_q.size() == 0 || req_cyc_q.size() == 0) begin
                abort_run("Response arrived with no request outstanding");
            end else begin
                exp_resp = exp_resp_q.pop_front();
                exp_data = exp_data_q.pop_front();
                name     = name_q.pop_front();
                req_cyc  = req_cyc_q.pop_front();
                check_value({name, " latency"}, 32'(req_cyc + 3), 32'(cycle_cnt));
                check_value({name, " resp"}, exp_resp, 32'(rsp_o.resp));
                check_value({name, " rdata"}, exp_data, rsp_o.rdata);
            end
        end
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin : watchdog
        wait (req_total > 0);
        // Worst case per request is 3 idle cycles plus the pipeline
        repeat (req_total * 6 + RST_CYCLES + 50) @(posedge sys_clk);
        abort_run("Timeout, the responses did not all arrive in time");
    end

    initial begin : main_seq
        int gap;
        void'($urandom(1586));
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        $readmemh("verif/cfg_bus_stim.txt", stim_mem);
        req_total = count_requests();
        if (req_total == 0 || req_total == STIM_MAX) begin
            abort_run("Stimulus file is empty or lacks its end marker");
        end

        repeat (RST_CYCLES) @(posedge sys_clk);
        rst_n_i <= 1'b1;

        for (int i = 0; i < req_total; i++) begin
            send_request(i);
            gap = stim_mem[i*STIM_COLS][4] ? 0 : $urandom_range(2, 0);   // Bit 4 forces b2b
            repeat (gap) begin
                @(posedge sys_clk);
                req_valid_i <= 1'b0;
            end
        end
        @(posedge sys_clk);
        req_valid_i <= 1'b0;

        repeat (4) @(posedge sys_clk);   // Last response due three cycles after its request

        if (exp_resp_q.size() == 0 && req_cyc_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("Requests were left without a response");
        end
    end

endmodule

//--- verif/cfg_bus_stim.txt
// op addr wdata exp_resp exp_rdata, all hex
// op bit 0 write, bit 4 next request follows at once, ff ends the list
00 00000000 00000000 0 00000000
00 20000004 00000000 0 00000000
00 40000008 00000000 0 00000000
00 6000000c 00000000 0 00000000
00 80000004 00000000 0 00000000
01 00000004 11111111 0 00000000
01 20000004 22222222 0 00000000
01 4000000c 33333333 0 00000000
01 6000000c 55555555 0 00000000
01 80000008 66666666 0 00000000
00 00000004 00000000 0 11111111
00 20000004 00000000 0 22222222
00 4000000c 00000000 0 33333333
00 6000000c 00000000 0 55555555
00 80000008 00000000 0 66666666
00 00000000 00000000 0 00000000
00 40000008 00000000 0 00000000
// Ignored address bits
00 1ffffc04 00000000 0 11111111
00 00000015 00000000 0 11111111
01 0000ff13 44444444 0 00000000
00 00000000 00000000 0 44444444
00 3ffffff4 00000000 0 22222222
// Unmapped IDs 5 to 7
00 a0000004 00000000 3 00000000
01 c0000004 deadbeef 3 00000000
01 e0000000 cafef00d 3 00000000
00 e0000010 00000000 3 00000000
00 00000004 00000000 0 11111111
00 20000000 00000000 0 00000000
00 00000000 00000000 0 44444444
// Write then read with no idle cycle
11 80000000 77777777 0 00000000
00 80000000 00000000 0 77777777
11 6000000c 88888888 0 00000000
10 6000000c 00000000 0 88888888
11 6000000c 99999999 0 00000000
00 6000000c 00000000 0 99999999
ff 00000000 00000000 0 00000000

//--- project.f
rtl/cfg_bus_pkg.sv
rtl/cfg_addr_decoder.sv
rtl/cfg_reg_bank.sv
rtl/cfg_rsp_mux.sv
rtl/cfg_bus_top.sv
verif/cfg_bus_assertions.sv
verif/cfg_bus_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert \
    -f project.f --top-module cfg_bus_tb -o cfg_bus_sim \
    && ./obj_dir/cfg_bus_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
